//--- list.f
+incdir+include
hdl/instrPkg.sv
hdl/systemPkg.sv
hdl/instrIngress.sv
hdl/sysDecode.sv
hdl/systemRegs.sv
hdl/resultEgress.sv
hdl/sysCtrlTop.sv
testbench/tbSysCtrl.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbSysCtrl -f list.f --Mdir "$BUILD" -o simSysCtrl
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD/simSysCtrl" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' "$LOG"; then
    echo "run passed"
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- testbench/tbSysCtrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "sysCtrl_defs.svh"

module tbSysCtrl;

    localparam int NUM_INSTR = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 30 + 100;
    localparam logic [31:0] SEED = 32'hccb4_92d8;

    logic                    clk;
    logic                    reset;
    logic                    instrReq;
    logic                    instrAck;
    logic [`SYS_DATA_W-1:0]  instr;
    logic [`SYS_DATA_W-1:0]  operand;
    logic [`SYS_FLAGS_W-1:0] resultFlags;
    logic                    excPending;
    logic [`SYS_CAUSE_W-1:0] cause;
    logic                    resultReq;
    logic                    resultAck;
    logic [`SYS_DATA_W-1:0]  resultData;

    // reference model of the system registers
    logic [3:0]  mFlags;
    logic        mIntEn;
    logic [15:0] mMask;
    logic [31:0] mIsr;
    logic [7:0]  mCall;

    logic [31:0] expQ[$];       // expected words in issue order
    string       nameQ[$];
    logic [31:0] stimState;
    int          sent = 0;
    int          received = 0;
    int          cycles = 0;
    int          dataErrors = 0;
    int          protoErrors = 0;
    int          countErrors = 0;

    logic        prevInstrReq = 1'b0;
    logic        prevInstrAck = 1'b0;
    logic        prevResultReq = 1'b0;
    logic        prevResultAck = 1'b0;
    logic [31:0] prevData = '0;

    sysCtrlTop DUT (
        .clk(clk), .reset(reset),
        .instrReq(instrReq), .instrAck(instrAck),
        .instr(instr), .operand(operand), .resultFlags(resultFlags),
        .excPending(excPending), .cause(cause),
        .resultReq(resultReq), .resultAck(resultAck), .resultData(resultData)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] drawStim();
        stimState = xorshift(stimState);
        return stimState;
    endfunction

    // weighted toward WSR and RSR, a few unused codes
    function automatic logic [5:0] randomOp();
        logic [31:0] r;
        r = drawStim();
        case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4: return instrPkg::WSR;
            4'd5, 4'd6, 4'd7, 4'd8:       return instrPkg::RSR;
            4'd9:  return instrPkg::SYSCALL;
            4'd10: return instrPkg::EI;
            4'd11: return instrPkg::DI;
            4'd12: return instrPkg::SETF;
            4'd13: return instrPkg::NOP;
            default: return 6'd7 + 6'(r[15:8] % 8'd57);
        endcase
    endfunction

    function automatic logic [4:0] randomIndex();
        logic [31:0] r;
        r = drawStim();
        if (r[3:0] == 4'd0)
            return 5'd5 + 5'(r[11:4] % 8'd27);     // out of range
        return 5'(r[11:4] % 8'd5);
    endfunction

    // read layout from the state before the update
    function automatic logic [31:0] modelRead(input logic [4:0] sra, input logic [4:0] c);
        case (sra)
            5'd0:    return {28'd0, mFlags};
            5'd1:    return {mMask, mIntEn, 10'd0, c};
            5'd2:    return mIsr;
            5'd3:    return {24'd0, mCall};
            default: return 32'd0;
        endcase
    endfunction

    task automatic modelUpdate(input logic [5:0] op, input logic [4:0] drl,
                               input logic [15:0] imm, input logic [31:0] opnd,
                               input logic [3:0] rf, input logic exc);
        if (!exc) begin
            case (op)
                instrPkg::WSR: begin
                    if (drl == 5'd0) begin
                        mFlags = opnd[3:0];
                    end else if (drl == 5'd1) begin
                        mIntEn = opnd[15];
                        mMask  = opnd[31:16];
                    end else if (drl == 5'd2) begin
                        mIsr = opnd;
                    end
                end
                instrPkg::SETF: mFlags = rf;
                instrPkg::EI:   mIntEn = 1'b1;
                instrPkg::DI:   mIntEn = 1'b0;
                default: ;
            endcase
        end
        if (op == instrPkg::SYSCALL)
            mCall = imm[7:0];       // latched even under an exception
    endtask

    // predict, then run one four-phase transfer on the inbound port
    task automatic sendInstr(input logic [5:0] op, input logic [4:0] drl,
                             input logic [4:0] sra, input logic exc, input string name);
        logic [31:0] r;
        logic [15:0] imm;
        logic [31:0] opnd;
        logic [3:0]  rf;
        logic [4:0]  c;
        r    = drawStim();
        imm  = r[15:0];
        opnd = drawStim();
        r    = drawStim();
        rf   = r[3:0];
        c    = r[8:4];
        expQ.push_back(modelRead(sra, c));
        nameQ.push_back(name);
        modelUpdate(op, drl, imm, opnd, rf, exc);
        sent++;
        @(posedge clk);
        instr       <= {op, drl, sra, imm};
        operand     <= opnd;
        resultFlags <= rf;
        excPending  <= exc;
        cause       <= c;
        instrReq    <= 1'b1;
        do @(posedge clk); while (!instrAck);
        instrReq <= 1'b0;
        do @(posedge clk); while (instrAck);
    endtask

    initial begin
        logic [31:0] r;
        clk = 1'b0;
        reset = 1'b1;
        instrReq = 1'b0;
        instr = '0;
        operand = '0;
        resultFlags = '0;
        excPending = 1'b0;
        cause = '0;
        stimState = SEED;
        mFlags = 4'd0;
        mIntEn = 1'b0;
        mMask = 16'd0;
        mIsr = 32'd4;
        mCall = 8'd0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < 4; i++)
            sendInstr(instrPkg::RSR, 5'd0, 5'(i), 1'b0, "resetState");

        sendInstr(instrPkg::WSR, 5'd0, 5'd3, 1'b0, "writeRead");
        sendInstr(instrPkg::WSR, 5'd1, 5'd0, 1'b0, "writeRead");
        sendInstr(instrPkg::WSR, 5'd2, 5'd1, 1'b0, "writeRead");
        sendInstr(instrPkg::WSR, 5'd3, 5'd2, 1'b0, "writeRead");   // sys3 not writable
        sendInstr(instrPkg::WSR, 5'd17, 5'd2, 1'b0, "writeRead");
        for (int i = 0; i < 4; i++)
            sendInstr(instrPkg::RSR, 5'd0, 5'(i), 1'b0, "writeRead");
        sendInstr(instrPkg::RSR, 5'd0, 5'd9, 1'b0, "writeRead");

        sendInstr(instrPkg::WSR, 5'd0, 5'd0, 1'b1, "excSuppress");
        sendInstr(instrPkg::WSR, 5'd1, 5'd1, 1'b1, "excSuppress");
        sendInstr(instrPkg::WSR, 5'd2, 5'd2, 1'b1, "excSuppress");
        sendInstr(instrPkg::SETF, 5'd0, 5'd0, 1'b1, "excSuppress");
        sendInstr(instrPkg::EI, 5'd0, 5'd1, 1'b1, "excSuppress");
        sendInstr(instrPkg::DI, 5'd0, 5'd1, 1'b1, "excSuppress");
        sendInstr(instrPkg::SYSCALL, 5'd0, 5'd3, 1'b1, "excSuppress");
        for (int i = 0; i < 4; i++)
            sendInstr(instrPkg::RSR, 5'd0, 5'(i), 1'b0, "excSuppress");

        sendInstr(instrPkg::SETF, 5'd0, 5'd0, 1'b0, "selectors");
        sendInstr(instrPkg::EI, 5'd0, 5'd0, 1'b0, "selectors");
        sendInstr(instrPkg::DI, 5'd0, 5'd1, 1'b0, "selectors");
        sendInstr(instrPkg::EI, 5'd0, 5'd1, 1'b0, "selectors");
        sendInstr(instrPkg::RSR, 5'd0, 5'd1, 1'b0, "selectors");

        while (sent < NUM_INSTR) begin
            r = drawStim();
            sendInstr(randomOp(), randomIndex(), randomIndex(), (r % 32'd6) == 32'd0,
                      "random");
        end

        while (received < NUM_INSTR)
            @(posedge clk);
        repeat (20) @(posedge clk);    // room for a stray extra result
        if (received != NUM_INSTR || expQ.size() != 0) begin
            $display("result count wrong: %0d received for %0d sent", received, NUM_INSTR);
            countErrors++;
        end
        $display("errors: data %0d, protocol %0d, count %0d",
                 dataErrors, protoErrors, countErrors);
        if (dataErrors + protoErrors + countErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // consumer side, random ack delay per word
    initial begin
        int          delay;
        logic [31:0] respState;
        logic [31:0] expected;
        string       name;
        resultAck = 1'b0;
        respState = SEED ^ 32'h0f0f_a5a5;
        forever begin
            @(posedge clk);
            if (!reset && resultReq) begin
                if (expQ.size() == 0) begin
                    $display("result word %h arrived with no instruction outstanding",
                             resultData);
                    countErrors++;
                end else begin
                    expected = expQ.pop_front();
                    name = nameQ.pop_front();
                    if (resultData !== expected) begin
                        $display("[FAIL] %s: expected %h, actual %h", name, expected,
                                 resultData);
                        dataErrors++;
                    end
                end
                received++;
                respState = xorshift(respState);
                delay = int'(respState[2:0]);
                repeat (delay) @(posedge clk);
                resultAck <= 1'b1;
                do @(posedge clk); while (resultReq);
                resultAck <= 1'b0;
            end
        end
    end

    // handshake rules on both external ports
    always @(posedge clk) begin
        if (!reset) begin
            if (instrAck && !prevInstrAck && !prevInstrReq) begin
                $display("protocol error: instrAck rose while instrReq was low");
                protoErrors++;
            end
            if (resultReq && prevResultReq && resultData !== prevData) begin
                $display("protocol error: resultData changed while resultReq was high");
                protoErrors++;
            end
            if (!resultReq && prevResultReq && !prevResultAck) begin
                $display("protocol error: resultReq fell before resultAck was seen");
                protoErrors++;
            end
        end
        prevInstrReq  <= instrReq;
        prevInstrAck  <= instrAck;
        prevResultReq <= resultReq;
        prevResultAck <= resultAck;
        prevData      <= resultData;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d of %0d results received",
                     TIMEOUT_CYCLES, received, NUM_INSTR);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- hdl/sysCtrlTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "sysCtrl_defs.svh"

module sysCtrlTop (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    instrReq,
    output logic                         instrAck,
    input  wire logic [`SYS_DATA_W-1:0]  instr,
    input  wire logic [`SYS_DATA_W-1:0]  operand,
    input  wire logic [`SYS_FLAGS_W-1:0] resultFlags,
    input  wire logic                    excPending,
    input  wire logic [`SYS_CAUSE_W-1:0] cause,
    output logic                         resultReq,
    input  wire logic                    resultAck,
    output logic [`SYS_DATA_W-1:0]       resultData
);

    // ingress to decode
    logic                    ingValid, ingReady;
    logic [`SYS_DATA_W-1:0]  ingInstr, ingOperand;
    logic [`SYS_FLAGS_W-1:0] ingFlags;
    logic                    ingExc;
    logic [`SYS_CAUSE_W-1:0] ingCause;

    // decode to execute
    logic                    decValid, decReady;
    logic [`SYS_DATA_W-1:0]  decInstr, decOperand;
    logic [`SYS_FLAGS_W-1:0] decFlags;
    logic                    decExc;
    logic [`SYS_CAUSE_W-1:0] decCause;
    systemPkg::controlBus    decCtrl;

    // execute to egress
    logic                    exeValid, exeReady;
    logic [`SYS_DATA_W-1:0]  exeResult;

    instrIngress ingress (
        .clk(clk), .reset(reset),
        .req(instrReq), .ack(instrAck),
        .instr(instr), .operand(operand), .resultFlags(resultFlags),
        .excPending(excPending), .cause(cause),
        .outValid(ingValid), .outReady(ingReady),
        .outInstr(ingInstr), .outOperand(ingOperand), .outFlags(ingFlags),
        .outExc(ingExc), .outCause(ingCause)
    );

    sysDecode decode (
        .clk(clk), .reset(reset),
        .inValid(ingValid), .inReady(ingReady),
        .inInstr(ingInstr), .inOperand(ingOperand), .inFlags(ingFlags),
        .inExc(ingExc), .inCause(ingCause),
        .outValid(decValid), .outReady(decReady),
        .outInstr(decInstr), .outOperand(decOperand), .outFlags(decFlags),
        .outExc(decExc), .outCause(decCause), .outCtrl(decCtrl)
    );

    systemRegs execute (
        .clk(clk), .reset(reset),
        .inValid(decValid), .inReady(decReady),
        .instr(decInstr), .operand(decOperand), .resultFlags(decFlags),
        .excPending(decExc), .cause(decCause), .ctrl(decCtrl),
        .outValid(exeValid), .outReady(exeReady), .result(exeResult)
    );

    resultEgress egress (
        .clk(clk), .reset(reset),
        .inValid(exeValid), .inReady(exeReady), .inData(exeResult),
        .req(resultReq), .ack(resultAck), .data(resultData)
    );

endmodule

`default_nettype wire

//--- hdl/resultEgress.sv
`timescale 1ns/1ps
`default_nettype none

`include "sysCtrl_defs.svh"

module resultEgress (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   inValid,
    output logic                        inReady,
    input  wire logic [`SYS_DATA_W-1:0] inData,
    output logic                        req,
    input  wire logic                   ack,
    output logic [`SYS_DATA_W-1:0]      data
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,        // word offered, waiting for ack
        WAITLOW     // req dropped, waiting for ack to fall
    } egressState;

    egressState state;
    logic       accept;

    // a new word can go in once ack is seen low again
    assign inReady = (state == IDLE) || (state == WAITLOW && !ack);
    assign accept  = inValid && inReady;
    assign req     = (state == REQ);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (accept) state <= REQ;
                REQ:     if (ack) state <= WAITLOW;
                WAITLOW: begin
                    if (accept)
                        state <= REQ;
                    else if (!ack)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            data <= inData;
    end

    assert property (@(posedge clk) disable iff (reset) req |=> !req || $stable(data));

endmodule

`default_nettype wire

//--- hdl/systemRegs.sv
`timescale 1ns/1ps
`default_nettype none

`include "sysCtrl_defs.svh"

module systemRegs (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    inValid,
    output logic                         inReady,
    input  wire logic [`SYS_DATA_W-1:0]  instr,
    input  wire logic [`SYS_DATA_W-1:0]  operand,
    input  wire logic [`SYS_FLAGS_W-1:0] resultFlags,
    input  wire logic                    excPending,
    input  wire logic [`SYS_CAUSE_W-1:0] cause,
    input  wire systemPkg::controlBus    ctrl,
    output logic                         outValid,
    input  wire logic                    outReady,
    output logic [`SYS_DATA_W-1:0]       result
);

    instrPkg::instrWord word;
    logic accept;
    logic commit;       // accepted and no exception pending

    logic [`SYS_FLAGS_W-1:0] flags;
    logic                    intEn;
    logic [`SYS_MASK_W-1:0]  mask;
    logic [`SYS_DATA_W-1:0]  isrBase;
    logic [`SYS_CALL_W-1:0]  sysCall;

    logic drlFlags, drlMask, drlIsr;
    logic flagsWr, intEnWr, maskWr, isrWr;
    logic [`SYS_FLAGS_W-1:0] flagsNext;
    logic                    intEnNext;
    logic [`SYS_DATA_W-1:0]  readData;

    assign word    = instrPkg::instrWord'(instr);
    assign inReady = !outValid || outReady;     // writes wait while egress is full
    assign accept  = inValid && inReady;
    assign commit  = accept && !excPending;

    // DRL write decoder
    always_comb begin
        drlFlags = 1'b0;
        drlMask  = 1'b0;
        drlIsr   = 1'b0;
        if (ctrl.writeEn && word.drl[4:2] == 3'd0) begin   // indices 4 and up hit nothing
            case (systemPkg::sysReg'(word.drl[1:0]))
                systemPkg::SYS_FLAGS: drlFlags = 1'b1;
                systemPkg::SYS_MASK:  drlMask  = 1'b1;
                systemPkg::SYS_ISR:   drlIsr   = 1'b1;
                default: ;                          // sys3 not writable by WSR
            endcase
        end
    end

    assign flagsWr = commit && (drlFlags || ctrl.flagsEn);
    assign intEnWr = commit && (drlMask || ctrl.intEnEn);
    assign maskWr  = commit && drlMask;
    assign isrWr   = commit && drlIsr;

    always_comb begin
        case (ctrl.flagsSelect)
            systemPkg::OPERAND: flagsNext = operand[`SYS_FLAGS_W-1:0];
            default:            flagsNext = resultFlags;
        endcase
    end

    always_comb begin
        case (ctrl.intEnSelect)
            systemPkg::CLEAR: intEnNext = 1'b0;
            systemPkg::SET:   intEnNext = 1'b1;
            default:          intEnNext = operand[15];
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flags   <= '0;
            intEn   <= 1'b0;
            mask    <= '0;
            isrBase <= `SYS_ISR_RESET;
            sysCall <= '0;
        end else begin
            if (flagsWr) flags <= flagsNext;
            if (intEnWr) intEn <= intEnNext;
            if (maskWr)  mask <= operand[`SYS_DATA_W-1:`SYS_DATA_W-`SYS_MASK_W];
            if (isrWr)   isrBase <= operand;
            if (accept && ctrl.sysCallEn)   // taken even with an exception pending
                sysCall <= word.imm16[`SYS_CALL_W-1:0];
        end
    end

    // SRA read mux sees the state from before this instruction's update
    always_comb begin
        readData = '0;
        if (word.sra[4:2] == 3'd0) begin
            case (systemPkg::sysReg'(word.sra[1:0]))
                systemPkg::SYS_FLAGS: readData = {{(`SYS_DATA_W-`SYS_FLAGS_W){1'b0}}, flags};
                systemPkg::SYS_MASK:  readData = {mask, intEn,
                    {(`SYS_DATA_W-`SYS_MASK_W-1-`SYS_CAUSE_W){1'b0}}, cause};
                systemPkg::SYS_ISR:   readData = isrBase;
                default:              readData = {{(`SYS_DATA_W-`SYS_CALL_W){1'b0}}, sysCall};
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            outValid <= 1'b0;
        else if (accept)
            outValid <= 1'b1;
        else if (outReady)
            outValid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept)
            result <= readData;
    end

    // decoder and control bus together must pick one target
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({flagsWr, maskWr, isrWr}));

endmodule

`default_nettype wire

//--- hdl/sysDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "sysCtrl_defs.svh"

module sysDecode (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    inValid,
    output logic                         inReady,
    input  wire logic [`SYS_DATA_W-1:0]  inInstr,
    input  wire logic [`SYS_DATA_W-1:0]  inOperand,
    input  wire logic [`SYS_FLAGS_W-1:0] inFlags,
    input  wire logic                    inExc,
    input  wire logic [`SYS_CAUSE_W-1:0] inCause,
    output logic                         outValid,
    input  wire logic                    outReady,
    output logic [`SYS_DATA_W-1:0]       outInstr,
    output logic [`SYS_DATA_W-1:0]       outOperand,
    output logic [`SYS_FLAGS_W-1:0]      outFlags,
    output logic                         outExc,
    output logic [`SYS_CAUSE_W-1:0]      outCause,
    output systemPkg::controlBus         outCtrl
);

    instrPkg::instrWord   word;
    systemPkg::controlBus ctrlNext;
    logic                 accept;

    assign word    = instrPkg::instrWord'(inInstr);
    assign inReady = !outValid || outReady;
    assign accept  = inValid && inReady;

    // opcode to control bus
    always_comb begin
        case (word.op)
            instrPkg::WSR:     ctrlNext = systemPkg::CTRL_WSR;
            instrPkg::RSR:     ctrlNext = systemPkg::CTRL_RSR;
            instrPkg::SYSCALL: ctrlNext = systemPkg::CTRL_SYSCALL;
            instrPkg::EI:      ctrlNext = systemPkg::CTRL_EI;
            instrPkg::DI:      ctrlNext = systemPkg::CTRL_DI;
            instrPkg::SETF:    ctrlNext = systemPkg::CTRL_SETF;
            default:           ctrlNext = systemPkg::CTRL_NOP;  // NOP and unused codes
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            outValid <= 1'b0;
        else if (accept)
            outValid <= 1'b1;
        else if (outReady)
            outValid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            outInstr   <= inInstr;
            outOperand <= inOperand;
            outFlags   <= inFlags;
            outExc     <= inExc;
            outCause   <= inCause;
            outCtrl    <= ctrlNext;
        end
    end

    // a stalled bus must not change under the execute stage
    assert property (@(posedge clk) disable iff (reset)
        outValid && !outReady |=> $stable(outCtrl));

endmodule

`default_nettype wire

//--- hdl/instrIngress.sv
`timescale 1ns/1ps
`default_nettype none

`include "sysCtrl_defs.svh"

module instrIngress (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    req,
    output logic                         ack,
    input  wire logic [`SYS_DATA_W-1:0]  instr,
    input  wire logic [`SYS_DATA_W-1:0]  operand,
    input  wire logic [`SYS_FLAGS_W-1:0] resultFlags,
    input  wire logic                    excPending,
    input  wire logic [`SYS_CAUSE_W-1:0] cause,
    output logic                         outValid,
    input  wire logic                    outReady,
    output logic [`SYS_DATA_W-1:0]       outInstr,
    output logic [`SYS_DATA_W-1:0]       outOperand,
    output logic [`SYS_FLAGS_W-1:0]      outFlags,
    output logic                         outExc,
    output logic [`SYS_CAUSE_W-1:0]      outCause
);

    typedef enum logic [1:0] {
        IDLE,
        ACKED,      // ack high, waiting for req to drop
        RELEASE     // ack back low
    } ingressState;

    ingressState state;
    logic slotFull;
    logic slotFree;
    logic capture;

    assign slotFree = !slotFull || (outValid && outReady);
    assign capture  = (state == IDLE) && req && slotFree;
    assign ack      = (state == ACKED);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (capture) state <= ACKED;
                ACKED:   if (!req) state <= RELEASE;
                RELEASE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // valid trails the capture by one cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            slotFull <= 1'b0;
            outValid <= 1'b0;
        end else begin
            if (capture)
                slotFull <= 1'b1;
            else if (outValid && outReady)
                slotFull <= 1'b0;

            if (outValid && outReady)
                outValid <= 1'b0;
            else if (slotFull)
                outValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            outInstr   <= instr;
            outOperand <= operand;
            outFlags   <= resultFlags;
            outExc     <= excPending;
            outCause   <= cause;
        end
    end

    // ack only answers a request seen on the edge before
    assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> $past(req));

endmodule

`default_nettype wire

//--- hdl/systemPkg.sv
`default_nettype none

package systemPkg;

    // flags source
    typedef enum logic {
        RESULT  = 1'b0,     // alu result flags
        OPERAND = 1'b1      // operand bits 3..0
    } flagsSel;

    // interrupt enable source
    typedef enum logic [1:0] {
        LOAD  = 2'b00,      // operand bit 15
        CLEAR = 2'b01,
        SET   = 2'b10
    } intEnSel;

    // system register index
    typedef enum logic [1:0] {
        SYS_FLAGS = 2'd0,
        SYS_MASK  = 2'd1,   // mask, int enable and cause
        SYS_ISR   = 2'd2,
        SYS_CALL  = 2'd3
    } sysReg;

    typedef struct packed {
        logic       writeEn;    // WSR, target picked by DRL
        logic       flagsEn;
        logic       sysCallEn;
        logic       intEnEn;
        intEnSel    intEnSelect;
        flagsSel    flagsSelect;
    } controlBus;

    // one bus per opcode
    localparam controlBus CTRL_NOP =
        '{writeEn: 1'b0, flagsEn: 1'b0, sysCallEn: 1'b0, intEnEn: 1'b0,
          intEnSelect: LOAD, flagsSelect: RESULT};
    localparam controlBus CTRL_WSR =
        '{writeEn: 1'b1, flagsEn: 1'b0, sysCallEn: 1'b0, intEnEn: 1'b0,
          intEnSelect: LOAD, flagsSelect: OPERAND};
    localparam controlBus CTRL_RSR = CTRL_NOP;  // read needs no update
    localparam controlBus CTRL_SYSCALL =
        '{writeEn: 1'b0, flagsEn: 1'b0, sysCallEn: 1'b1, intEnEn: 1'b0,
          intEnSelect: LOAD, flagsSelect: RESULT};
    localparam controlBus CTRL_EI =
        '{writeEn: 1'b0, flagsEn: 1'b0, sysCallEn: 1'b0, intEnEn: 1'b1,
          intEnSelect: SET, flagsSelect: RESULT};
    localparam controlBus CTRL_DI =
        '{writeEn: 1'b0, flagsEn: 1'b0, sysCallEn: 1'b0, intEnEn: 1'b1,
          intEnSelect: CLEAR, flagsSelect: RESULT};
    localparam controlBus CTRL_SETF =
        '{writeEn: 1'b0, flagsEn: 1'b1, sysCallEn: 1'b0, intEnEn: 1'b0,
          intEnSelect: LOAD, flagsSelect: RESULT};

endpackage

`default_nettype wire

//--- hdl/instrPkg.sv
`default_nettype none

package instrPkg;

    // major opcode, instruction bits 31..26
    typedef enum logic [5:0] {
        NOP     = 6'd0,
        WSR     = 6'd1,     // write sys reg DRL from operand
        RSR     = 6'd2,     // read only
        SYSCALL = 6'd3,
        EI      = 6'd4,
        DI      = 6'd5,
        SETF    = 6'd6      // flags from alu result flags
    } opcode;

    // register select field, used for DRL and SRA
    typedef logic [4:0] regField;

    // instruction word as seen by the system control slice
    typedef struct packed {
        opcode      op;     // 31..26
        regField    drl;    // 25..21, destination
        regField    sra;    // 20..16, read source
        logic [15:0] imm16;
    } instrWord;

endpackage

`default_nettype wire

//--- include/sysCtrl_defs.svh
`ifndef SYS_CTRL_DEFS_SVH
`define SYS_CTRL_DEFS_SVH

// instruction and data word width
`define SYS_DATA_W      32

// alu result flags carried with each instruction
`define SYS_FLAGS_W     4

// exception cause code
`define SYS_CAUSE_W     5

// sys1 upper half holds the exception mask
`define SYS_MASK_W      16

// sys3 keeps the low byte of imm16
`define SYS_CALL_W      8

// isr base comes out of reset pointing past the reset vector
`define SYS_ISR_RESET   32'd4

`endif
